//--- source/nora_pkg.sv
// Shared constants and enums for the CPU bus core
// BLINK_DIV is kept short for simulation; raise it for a visible blink on hardware
package nora_pkg;

    // CPU and memory bus widths
    localparam int ADDR_W = 16;         // Full CPU address
    localparam int DATA_W = 8;          // CPU and SRAM data bus
    localparam int CA_W   = 4;          // Private high address pins
    localparam int MAL_W  = 12;         // Shared low address pins

    // VIA window, decoded on bits 15..4
    localparam logic [ADDR_W-1:0] VIA_BASE = 16'h9F00;

    // Timing
    localparam int RST_STRETCH = 16;            // CPU reset hold after internal release
    localparam logic [15:0] BLINK_DIV = 16'd64; // Ticks between LED toggles

    // Port B input, constant upper bits
    localparam logic [5:0] IRB_FIXED = 6'b110000;

    // Six phases of one CPU cycle
    typedef enum logic [2:0]
    {
        PH0,    // CPHI2 low
        PH1,    // Address setup
        PH2,
        PH3,    // CPHI2 high
        PH4,    // Write release
        PH5     // Select release
    } phase_e;

    // VIA register indices
    typedef enum logic [3:0]
    {
        REG_ORB    = 4'd0,
        REG_ORA    = 4'd1,
        REG_DDRB   = 4'd2,
        REG_DDRA   = 4'd3,
        REG_ORA_NH = 4'd15  // ORA without handshake
    } via_reg_e;

endpackage

//--- source/nora_slv_if.sv
// One internal slave access, no handshake
// req spans the access, datawr_valid pulses once at the write release
`timescale 1ns/1ps

interface nora_slv_if;
    import nora_pkg::*;

    logic [3:0]        addr;            // Register index within the device
    logic [DATA_W-1:0] datawr;          // Write data from the CPU bus
    logic              datawr_valid;    // One tick, write data is stable
    logic [DATA_W-1:0] datard;          // Combinational read data
    logic              req;             // Device selected for this access
    logic              rwn;             // 1 = read, 0 = write

    // Bus controller side
    modport bus (
        output addr, datawr, datawr_valid, req, rwn,
        input  datard
    );

    // Device side
    modport dev (
        input  addr, datawr, datawr_valid, req, rwn,
        output datard
    );

endinterface

//--- source/reset_gen.sv
// Async assert, sync release; CPU reset held RST_STRETCH ticks longer
`timescale 1ns/1ps

module reset_gen (
    input  logic clk6x,
    input  logic arst_n_i,
    output logic rst_n_o,       // Internal reset, synchronised
    output logic cpu_res_n_o    // Stretched CPU reset
);
    import nora_pkg::*;

    logic [1:0]                     sync_r;     // Two-flop synchroniser
    logic [$clog2(RST_STRETCH)-1:0] stretch_cnt;

    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
            sync_r <= 2'b00;
        else
            sync_r <= {sync_r[0], 1'b1};
    end

    assign rst_n_o = sync_r[1];

    // Count from internal release, then free the CPU
    always_ff @(posedge clk6x or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            stretch_cnt <= '0;
            cpu_res_n_o <= 1'b0;
        end
        else if (!rst_n_o)
        begin
            stretch_cnt <= '0;      // Still in internal reset
            cpu_res_n_o <= 1'b0;
        end
        else if (stretch_cnt != RST_STRETCH - 1)
            stretch_cnt <= stretch_cnt + 1'b1;
        else
            cpu_res_n_o <= 1'b1;    // Stays high until next reset
    end

endmodule

//--- source/cpu_phaser.sv
// Free-running six-tick CPU cycle after reset, no stretching
// All outputs are registered and aligned with phase_o
`timescale 1ns/1ps

module cpu_phaser (
    input  logic             clk6x,
    input  logic             rst_n_i,
    output logic             cphi2_o,       // CPU clock, high in PH3..PH5
    output nora_pkg::phase_e phase_o,       // Current phase
    output logic             setup_cs_o,    // High in PH1
    output logic             release_wr_o,  // High in PH4
    output logic             release_cs_o   // High in PH5
);
    import nora_pkg::*;

    phase_e phase_r;
    phase_e phase_nxt;

    // Wrap after the last phase
    always_comb
    begin
        if (phase_r == PH5)
            phase_nxt = PH0;
        else
            phase_nxt = phase_e'(phase_r + 3'd1);
    end

    // Strobes decoded one phase early so they line up with phase_r
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            phase_r      <= PH0;    // Hold PH0, clock low
            cphi2_o      <= 1'b0;
            setup_cs_o   <= 1'b0;
            release_wr_o <= 1'b0;
            release_cs_o <= 1'b0;
        end
        else
        begin
            phase_r      <= phase_nxt;
            cphi2_o      <= (phase_nxt == PH3) || (phase_nxt == PH4) ||
                            (phase_nxt == PH5);
            setup_cs_o   <= (phase_nxt == PH1);     // Address valid by now
            release_wr_o <= (phase_nxt == PH4);     // One tick of write hold
            release_cs_o <= (phase_nxt == PH5);     // End of access
        end
    end

    assign phase_o = phase_r;

endmodule

//--- source/bus_controller.sv
// Flat 64 KiB SRAM everywhere except the VIA window at 9F00..9F0F
// Relies on the CPU holding address and R/W stable from PH1 to the end of the cycle
`timescale 1ns/1ps

module bus_controller (
    input  logic                        clk6x,
    input  logic                        rst_n_i,
    input  logic                        setup_cs_i,     // Latch address, assert selects
    input  logic                        release_wr_i,   // Raise MWRn
    input  logic                        release_cs_i,   // End of access
    input  logic                        cphi2_i,
    input  logic [nora_pkg::CA_W-1:0]   ca_i,           // Address bits 15..12
    input  logic [nora_pkg::MAL_W-1:0]  mal_i,          // Address bits 11..0
    input  logic                        crwn_i,
    input  logic [nora_pkg::DATA_W-1:0] cd_i,
    input  logic [nora_pkg::DATA_W-1:0] md_i,
    output logic [nora_pkg::DATA_W-1:0] cd_o,
    output logic                        cd_oe_o,
    output logic [nora_pkg::DATA_W-1:0] md_o,
    output logic                        md_oe_o,
    output logic                        m1_csn_o,
    output logic                        mrdn_o,
    output logic                        mwrn_o,
    nora_slv_if.bus                     slv
);
    import nora_pkg::*;

    logic [ADDR_W-1:0] cpu_addr;
    logic              via_hit;         // Address in VIA window
    logic [3:0]        reg_addr_r;      // Only the register index is kept
    logic              active_r;        // PH2..PH5 of any access
    logic              rwn_r;
    logic              via_r;
    logic              csn_r, rdn_r, wrn_r;

    assign cpu_addr = {ca_i, mal_i};
    assign via_hit  = (cpu_addr[ADDR_W-1:4] == VIA_BASE[ADDR_W-1:4]);

    always_ff @(posedge clk6x)
    begin
        if (setup_cs_i)
            reg_addr_r <= cpu_addr[3:0];
    end

    // Access state and SRAM strobes
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            active_r <= 1'b0;
            rwn_r    <= 1'b1;
            via_r    <= 1'b0;
            csn_r    <= 1'b1;
            rdn_r    <= 1'b1;
            wrn_r    <= 1'b1;
        end
        else if (setup_cs_i)
        begin
            active_r <= 1'b1;
            rwn_r    <= crwn_i;
            via_r    <= via_hit;
            csn_r    <= via_hit;            // VIA leaves SRAM idle
            rdn_r    <= via_hit | ~crwn_i;
            wrn_r    <= via_hit | crwn_i;
        end
        else if (release_cs_i)
        begin
            active_r <= 1'b0;
            csn_r    <= 1'b1;
            rdn_r    <= 1'b1;
            wrn_r    <= 1'b1;
        end
        else if (release_wr_i)
            wrn_r <= 1'b1;                  // Hold one tick before CS rises
    end

    // SRAM side
    assign m1_csn_o = csn_r;
    assign mrdn_o   = rdn_r;
    assign mwrn_o   = wrn_r;
    assign md_o     = cd_i;
    assign md_oe_o  = ~wrn_r;               // Drive only while writing

    // CPU read data during PHI2 high
    assign cd_oe_o = active_r & rwn_r & cphi2_i;
    assign cd_o    = via_r ? slv.datard : md_i;

    // Internal slave
    assign slv.addr         = reg_addr_r;
    assign slv.datawr       = cd_i;
    assign slv.datawr_valid = release_wr_i & active_r & ~rwn_r;
    assign slv.req          = active_r & via_r;
    assign slv.rwn          = rwn_r;

endmodule

//--- source/via_regs.sv
// GPIO part of a 65C22 only; no timers, shift register or interrupts
`timescale 1ns/1ps

module via_regs (
    input  logic                        clk6x,
    input  logic                        rst_n_i,
    input  logic [nora_pkg::DATA_W-1:0] ira_i,      // Port A pin levels
    input  logic [nora_pkg::DATA_W-1:0] irb_i,      // Port B pin levels
    output logic [nora_pkg::DATA_W-1:0] ora_o,
    output logic [nora_pkg::DATA_W-1:0] orb_o,
    output logic [nora_pkg::DATA_W-1:0] ddra_o,     // 1 = output
    output logic [nora_pkg::DATA_W-1:0] ddrb_o,
    nora_slv_if.dev                     slv
);
    import nora_pkg::*;

    logic [DATA_W-1:0] ora_r, orb_r, ddra_r, ddrb_r;
    logic              wr_en;
    via_reg_e          reg_sel;

    assign reg_sel = via_reg_e'(slv.addr);
    assign wr_en   = slv.req & slv.datawr_valid & ~slv.rwn;

    // All zero after reset, every pin an input
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ora_r  <= '0;
            orb_r  <= '0;
            ddra_r <= '0;
            ddrb_r <= '0;
        end
        else if (wr_en)
        begin
            case (reg_sel)
                REG_ORB:             orb_r  <= slv.datawr;
                REG_ORA, REG_ORA_NH: ora_r  <= slv.datawr;    // No handshake lines
                REG_DDRB:            ddrb_r <= slv.datawr;
                REG_DDRA:            ddra_r <= slv.datawr;
                default:             ;                        // Unused index
            endcase
        end
    end

    // Output bits from OR, input bits from the pins
    always_comb
    begin
        case (reg_sel)
            REG_ORB:             slv.datard = (orb_r & ddrb_r) | (irb_i & ~ddrb_r);
            REG_ORA, REG_ORA_NH: slv.datard = (ora_r & ddra_r) | (ira_i & ~ddra_r);
            REG_DDRB:            slv.datard = ddrb_r;
            REG_DDRA:            slv.datard = ddra_r;
            default:             slv.datard = '0;
        endcase
    end

    assign ora_o  = ora_r;
    assign orb_o  = orb_r;
    assign ddra_o = ddra_r;
    assign ddrb_o = ddrb_r;

endmodule

//--- source/gpio_port_map.sv
// Pads split into in/out/oe; SDA is open drain so only its enable leaves here
// The top level or board wrapper builds the tri-states
`timescale 1ns/1ps

module gpio_port_map (
    input  logic                        clk6x,
    input  logic                        rst_n_i,
    input  logic [nora_pkg::DATA_W-1:0] ora_i,
    input  logic [nora_pkg::DATA_W-1:0] orb_i,
    input  logic [nora_pkg::DATA_W-1:0] ddra_i,
    input  logic [nora_pkg::DATA_W-1:0] ddrb_i,
    input  logic                        nes_data0_i,
    input  logic                        nes_data1_i,
    input  logic                        i2c_scl_i,
    input  logic                        i2c_sda_i,
    output logic [nora_pkg::DATA_W-1:0] ira_o,
    output logic [nora_pkg::DATA_W-1:0] irb_o,
    output logic                        nes_clock_o,
    output logic                        nes_latch_o,
    output logic                        i2c_scl_o,
    output logic                        i2c_scl_oe_o,
    output logic                        i2c_sda_oe_o,   // 1 pulls SDA low
    output logic                        cpu_led0_o,
    output logic                        cpu_led1_o
);
    import nora_pkg::*;

    logic [$bits(BLINK_DIV)-1:0] blink_cnt;
    logic                        blink_r;

    // LED0 default blinker
    always_ff @(posedge clk6x or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            blink_cnt <= '0;
            blink_r   <= 1'b0;
        end
        else if (blink_cnt == BLINK_DIV - 16'd1)
        begin
            blink_cnt <= '0;
            blink_r   <= ~blink_r;
        end
        else
            blink_cnt <= blink_cnt + 1'b1;
    end

    assign nes_clock_o  = ddra_i[3] & ora_i[3];     // Low when input
    assign nes_latch_o  = ddra_i[2] & ora_i[2];
    assign i2c_scl_o    = ora_i[1];
    assign i2c_scl_oe_o = ddra_i[1];                // Released when input
    assign i2c_sda_oe_o = ddra_i[0] & ~ora_i[0];

    assign cpu_led0_o = ddrb_i[0] ? orb_i[0] : blink_r;
    assign cpu_led1_o = ddrb_i[1] ? orb_i[1] : 1'b1;

    // Pin levels as the VIA sees them
    assign ira_o = {nes_data0_i, nes_data1_i, 2'b11, nes_clock_o, nes_latch_o,
                    i2c_scl_i, i2c_sda_i};
    assign irb_o = {IRB_FIXED, cpu_led1_o, cpu_led0_o};

endmodule

//--- source/nora_core.sv
// CPU bus core top level; pads appear as separate in/out/oe ports
// No PLL here, clk6x must already be six times the CPU clock
`timescale 1ns/1ps

module nora_core (
    input  logic                        clk6x,
    input  logic                        arst_n_i,
    // CPU bus
    input  logic [nora_pkg::CA_W-1:0]   ca_i,
    input  logic [nora_pkg::MAL_W-1:0]  mal_i,
    input  logic                        crwn_i,
    input  logic [nora_pkg::DATA_W-1:0] cd_i,
    output logic [nora_pkg::DATA_W-1:0] cd_o,
    output logic                        cd_oe_o,
    output logic                        cresn_o,
    output logic                        cphi2_o,
    output logic                        cirq_n_o,
    input  logic                        virq_n_i,   // IRQ from the video side
    // SRAM
    input  logic [nora_pkg::DATA_W-1:0] md_i,
    output logic [nora_pkg::DATA_W-1:0] md_o,
    output logic                        md_oe_o,
    output logic                        m1_csn_o,
    output logic                        mrdn_o,
    output logic                        mwrn_o,
    // GPIO pins
    input  logic                        nes_data0_i,
    input  logic                        nes_data1_i,
    output logic                        nes_clock_o,
    output logic                        nes_latch_o,
    input  logic                        i2c_scl_i,
    output logic                        i2c_scl_o,
    output logic                        i2c_scl_oe_o,
    input  logic                        i2c_sda_i,
    output logic                        i2c_sda_oe_o,
    output logic                        cpu_led0_o,
    output logic                        cpu_led1_o
);
    import nora_pkg::*;

    logic              rst_n;
    logic              setup_cs, release_wr, release_cs;
    logic [DATA_W-1:0] ora, orb, ddra, ddrb;
    logic [DATA_W-1:0] ira, irb;

    nora_slv_if u_slv_if ();

    reset_gen u_reset_gen (
        .clk6x       (clk6x),
        .arst_n_i    (arst_n_i),
        .rst_n_o     (rst_n),
        .cpu_res_n_o (cresn_o)
    );

    cpu_phaser u_cpu_phaser (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n),
        .cphi2_o      (cphi2_o),
        .phase_o      (),           // Spare for debug
        .setup_cs_o   (setup_cs),
        .release_wr_o (release_wr),
        .release_cs_o (release_cs)
    );

    bus_controller u_bus_controller (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n),
        .setup_cs_i   (setup_cs),
        .release_wr_i (release_wr),
        .release_cs_i (release_cs),
        .cphi2_i      (cphi2_o),
        .ca_i         (ca_i),
        .mal_i        (mal_i),
        .crwn_i       (crwn_i),
        .cd_i         (cd_i),
        .md_i         (md_i),
        .cd_o         (cd_o),
        .cd_oe_o      (cd_oe_o),
        .md_o         (md_o),
        .md_oe_o      (md_oe_o),
        .m1_csn_o     (m1_csn_o),
        .mrdn_o       (mrdn_o),
        .mwrn_o       (mwrn_o),
        .slv          (u_slv_if.bus)
    );

    via_regs u_via_regs (
        .clk6x   (clk6x),
        .rst_n_i (rst_n),
        .ira_i   (ira),
        .irb_i   (irb),
        .ora_o   (ora),
        .orb_o   (orb),
        .ddra_o  (ddra),
        .ddrb_o  (ddrb),
        .slv     (u_slv_if.dev)
    );

    gpio_port_map u_gpio_port_map (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n),
        .ora_i        (ora),
        .orb_i        (orb),
        .ddra_i       (ddra),
        .ddrb_i       (ddrb),
        .nes_data0_i  (nes_data0_i),
        .nes_data1_i  (nes_data1_i),
        .i2c_scl_i    (i2c_scl_i),
        .i2c_sda_i    (i2c_sda_i),
        .ira_o        (ira),
        .irb_o        (irb),
        .nes_clock_o  (nes_clock_o),
        .nes_latch_o  (nes_latch_o),
        .i2c_scl_o    (i2c_scl_o),
        .i2c_scl_oe_o (i2c_scl_oe_o),
        .i2c_sda_oe_o (i2c_sda_oe_o),
        .cpu_led0_o   (cpu_led0_o),
        .cpu_led1_o   (cpu_led1_o)
    );

    assign cirq_n_o = virq_n_i;     // Only IRQ source in this build

endmodule

//--- sim/nora_checker.sv
// Watches the DUT pins on the falling clk6x edge, where all outputs are settled
// Row checks run on the last tick of CPHI2 high, so the CPU model must hold a row a whole cycle
`timescale 1ns/1ps

module nora_checker (
    input  logic        clk6x,
    input  logic        arst_n_i,
    input  logic        cphi2_i,
    input  logic [7:0]  cd_i,           // DUT read data toward the CPU
    input  logic        cd_oe_i,
    input  logic        m1_csn_i,
    input  logic        mrdn_i,
    input  logic        mwrn_i,
    input  logic        md_oe_i,
    input  logic        cresn_i,
    input  logic        virq_n_i,       // IRQ level driven into the DUT
    input  logic        cirq_n_i,       // IRQ level seen at the CPU pin
    input  logic [6:0]  pins_i,         // Clock, latch, SCL, SCL oe, SDA oe, LED1, LED0
    input  logic        row_valid_i,
    input  logic [95:0] row_name_i,
    input  logic        row_via_i,
    input  logic [7:0]  exp_rd_i,
    input  logic [7:0]  rd_mask_i,      // Zero on writes
    input  logic [6:0]  pin_mask_i,
    input  logic [6:0]  pin_exp_i,
    output int          err_cnt_o,
    output int          check_cnt_o
);
    int   hi_cnt;                       // Ticks of CPHI2 high in this cycle
    logic prev_cphi2, prev_csn, prev_wrn;
    logic wr_open, wr_rose;             // SRAM write in flight

    initial
    begin
        err_cnt_o   = 0;
        check_cnt_o = 0;
        hi_cnt      = 0;
        prev_cphi2  = 1'b0;
        prev_csn    = 1'b1;
        prev_wrn    = 1'b1;
        wr_open     = 1'b0;
        wr_rose     = 1'b0;
    end

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_cnt_o++;
        if (act !== exp)
        begin
            err_cnt_o++;
            $display("Fail reset_state %s: expected %b, actual %b", what, exp, act);
        end
    endtask

    task automatic compare_row();
        check_cnt_o++;
        if (rd_mask_i != 8'h00 && (!cd_oe_i || (cd_i & rd_mask_i) !== (exp_rd_i & rd_mask_i)))
        begin
            err_cnt_o++;
            $display("Fail %0s: expected data %h, actual %h (oe %b)", row_name_i,
                     exp_rd_i & rd_mask_i, cd_i & rd_mask_i, cd_oe_i);
        end
        if ((pins_i & pin_mask_i) !== (pin_exp_i & pin_mask_i))
        begin
            err_cnt_o++;
            $display("Fail %0s: expected pins %b, actual %b", row_name_i,
                     pin_exp_i & pin_mask_i, pins_i & pin_mask_i);
        end
        if (cirq_n_i !== virq_n_i)
        begin
            err_cnt_o++;
            $display("Fail %0s: expected irq %b, actual %b", row_name_i, virq_n_i, cirq_n_i);
        end
    endtask

    always @(negedge clk6x)
    begin
        if (!arst_n_i)
        begin
            check_bit("m1_csn", 1'b1, m1_csn_i);    // Everything idle in reset
            check_bit("mrdn", 1'b1, mrdn_i);
            check_bit("mwrn", 1'b1, mwrn_i);
            check_bit("cd_oe", 1'b0, cd_oe_i);
            check_bit("md_oe", 1'b0, md_oe_i);
            check_bit("cresn", 1'b0, cresn_i);
            check_bit("cphi2", 1'b0, cphi2_i);
        end
        else
        begin
            if (cphi2_i)
            begin
                hi_cnt++;
                if (hi_cnt == 3 && row_valid_i)
                    compare_row();                  // Last tick before CPHI2 falls
            end
            else if (prev_cphi2)
            begin
                check_cnt_o++;
                if (hi_cnt != 3)
                begin
                    err_cnt_o++;
                    $display("Fail cphi2_width: expected 3 high ticks, actual %0d", hi_cnt);
                end
                hi_cnt = 0;
            end
            if (prev_csn && !m1_csn_i && row_valid_i && row_via_i)
            begin
                err_cnt_o++;
                $display("SRAM select went low during VIA access %0s", row_name_i);
            end
            // Select release judged before this tick's strobe edge is counted
            if (!prev_csn && m1_csn_i)
            begin
                if (wr_open && !wr_rose)
                begin
                    err_cnt_o++;
                    $display("SRAM write strobe did not rise before the select released");
                end
                wr_open = 1'b0;
            end
            if (prev_wrn && !mwrn_i)
            begin
                wr_open = 1'b1;
                wr_rose = 1'b0;
            end
            if (!prev_wrn && mwrn_i)
                wr_rose = 1'b1;
        end
        prev_cphi2 = cphi2_i;
        prev_csn   = m1_csn_i;
        prev_wrn   = mwrn_i;
    end

endmodule

//--- sim/tb_nora_core.sv
// CPU model presents one table row per CPU cycle, right after CPHI2 falls
// SRAM model holds a full 64 KiB; pad inputs are tied to fixed levels
`timescale 1ns/1ps

module tb_nora_core;
    import nora_pkg::*;

    localparam int MAX_ROWS  = 32;
    localparam int SRC_FIX   = 0;   // Write data and expected read from the table
    localparam int SRC_LFSR  = 1;   // Write data from the LFSR, kept for readback
    localparam int SRC_QUEUE = 2;   // Expected read is the oldest LFSR byte

    logic        clk6x, arst_n_i;
    logic [3:0]  ca_i;
    logic [11:0] mal_i;
    logic        crwn_i, virq_n_i;
    logic [7:0]  cd_i, cd_o, md_i, md_o;
    logic        cd_oe_o, cresn_o, cphi2_o, cirq_n_o;
    logic        md_oe_o, m1_csn_o, mrdn_o, mwrn_o;
    logic        nes_data0_i, nes_data1_i, nes_clock_o, nes_latch_o;
    logic        i2c_scl_i, i2c_scl_o, i2c_scl_oe_o, i2c_sda_i, i2c_sda_oe_o;
    logic        cpu_led0_o, cpu_led1_o;

    // Stimulus table
    logic [95:0] t_name [MAX_ROWS];
    logic [15:0] t_addr [MAX_ROWS];
    logic        t_rwn [MAX_ROWS];
    logic [7:0]  t_wdata [MAX_ROWS];
    logic [7:0]  t_rdmask [MAX_ROWS];
    logic [7:0]  t_exprd [MAX_ROWS];
    int          t_src [MAX_ROWS];
    logic [6:0]  t_pmask [MAX_ROWS];
    logic [6:0]  t_pexp [MAX_ROWS];
    int          row_cnt;

    // Current row as seen by the checker
    logic [95:0] row_name;
    logic        row_valid, row_via;
    logic [7:0]  exp_rd, rd_mask;
    logic [6:0]  pin_mask, pin_exp;
    int          err_cnt, check_cnt, timeouts;

    logic [7:0]  mem [65536];       // SRAM model
    logic [7:0]  sram_q [$];        // LFSR bytes awaiting readback
    logic [31:0] lfsr_r;
    logic [6:0]  pins;

    always #10 clk6x = ~clk6x;

    assign pins = {nes_clock_o, nes_latch_o, i2c_scl_o, i2c_scl_oe_o, i2c_sda_oe_o,
                   cpu_led1_o, cpu_led0_o};

    // SRAM stores on the rising write strobe, drives only while read strobe is low
    always @(posedge mwrn_o)
        mem[{ca_i, mal_i}] <= md_o;
    assign md_i = !mrdn_o ? mem[{ca_i, mal_i}] : 8'h00;

    nora_core u_nora_core (
        .clk6x (clk6x), .arst_n_i (arst_n_i), .ca_i (ca_i), .mal_i (mal_i),
        .crwn_i (crwn_i), .cd_i (cd_i), .cd_o (cd_o), .cd_oe_o (cd_oe_o),
        .cresn_o (cresn_o), .cphi2_o (cphi2_o), .cirq_n_o (cirq_n_o),
        .virq_n_i (virq_n_i), .md_i (md_i), .md_o (md_o), .md_oe_o (md_oe_o),
        .m1_csn_o (m1_csn_o), .mrdn_o (mrdn_o), .mwrn_o (mwrn_o),
        .nes_data0_i (nes_data0_i), .nes_data1_i (nes_data1_i),
        .nes_clock_o (nes_clock_o), .nes_latch_o (nes_latch_o),
        .i2c_scl_i (i2c_scl_i), .i2c_scl_o (i2c_scl_o), .i2c_scl_oe_o (i2c_scl_oe_o),
        .i2c_sda_i (i2c_sda_i), .i2c_sda_oe_o (i2c_sda_oe_o),
        .cpu_led0_o (cpu_led0_o), .cpu_led1_o (cpu_led1_o)
    );

    nora_checker u_checker (
        .clk6x (clk6x), .arst_n_i (arst_n_i), .cphi2_i (cphi2_o), .cd_i (cd_o),
        .cd_oe_i (cd_oe_o), .m1_csn_i (m1_csn_o), .mrdn_i (mrdn_o), .mwrn_i (mwrn_o),
        .md_oe_i (md_oe_o), .cresn_i (cresn_o), .virq_n_i (virq_n_i),
        .cirq_n_i (cirq_n_o), .pins_i (pins),
        .row_valid_i (row_valid), .row_name_i (row_name), .row_via_i (row_via),
        .exp_rd_i (exp_rd), .rd_mask_i (rd_mask), .pin_mask_i (pin_mask),
        .pin_exp_i (pin_exp), .err_cnt_o (err_cnt), .check_cnt_o (check_cnt)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_byte(output logic [7:0] b);
        b = 8'h00;
        for (int k = 0; k < 8; k++)
        begin
            lfsr_r = lfsr_step(lfsr_r);
            b      = {b[6:0], lfsr_r[0]};   // One step per bit
        end
    endtask

    task automatic add_row(input logic [95:0] name, input logic [15:0] addr,
                           input logic rwn, input logic [7:0] wdata,
                           input logic [7:0] rdmask, input logic [7:0] exprd,
                           input int src, input logic [6:0] pmask,
                           input logic [6:0] pexp);
        t_name[row_cnt]   = name;
        t_addr[row_cnt]   = addr;
        t_rwn[row_cnt]    = rwn;
        t_wdata[row_cnt]  = wdata;
        t_rdmask[row_cnt] = rdmask;
        t_exprd[row_cnt]  = exprd;
        t_src[row_cnt]    = src;
        t_pmask[row_cnt]  = pmask;
        t_pexp[row_cnt]   = pexp;
        row_cnt++;
    endtask

    // Pad inputs: NES data0 1, data1 0, SCL 1, SDA 0; SRAM fill is A5 ^ lo ^ hi
    task automatic load_table();
        row_cnt = 0;
        add_row("after_reset", 16'h1234, 1'b1, 8'h00, 8'hFF, 8'h83, SRC_FIX, 7'h06, 7'h02);
        add_row("sram_wr0", 16'h0123, 1'b0, 8'h00, 8'h00, 8'h00, SRC_LFSR, 7'h00, 7'h00);
        add_row("sram_wr1", 16'h4567, 1'b0, 8'h00, 8'h00, 8'h00, SRC_LFSR, 7'h00, 7'h00);
        add_row("sram_wr2", 16'hA5F0, 1'b0, 8'h00, 8'h00, 8'h00, SRC_LFSR, 7'h00, 7'h00);
        add_row("sram_wr3", 16'hFFFE, 1'b0, 8'h00, 8'h00, 8'h00, SRC_LFSR, 7'h00, 7'h00);
        add_row("sram_rd0", 16'h0123, 1'b1, 8'h00, 8'hFF, 8'h00, SRC_QUEUE, 7'h00, 7'h00);
        add_row("sram_rd1", 16'h4567, 1'b1, 8'h00, 8'hFF, 8'h00, SRC_QUEUE, 7'h00, 7'h00);
        add_row("sram_rd2", 16'hA5F0, 1'b1, 8'h00, 8'hFF, 8'h00, SRC_QUEUE, 7'h00, 7'h00);
        add_row("sram_rd3", 16'hFFFE, 1'b1, 8'h00, 8'hFF, 8'h00, SRC_QUEUE, 7'h00, 7'h00);
        add_row("above_via", 16'h9F10, 1'b1, 8'h00, 8'hFF, 8'h2A, SRC_FIX, 7'h00, 7'h00);
        add_row("ddra_wr", 16'h9F03, 1'b0, 8'h0F, 8'h00, 8'h00, SRC_FIX, 7'h7C, 7'h0C);
        add_row("ora_wr", 16'h9F01, 1'b0, 8'h0C, 8'h00, 8'h00, SRC_FIX, 7'h7C, 7'h6C);
        add_row("ora_rd", 16'h9F01, 1'b1, 8'h00, 8'hFF, 8'hBC, SRC_FIX, 7'h7C, 7'h6C);
        add_row("ora_nh_wr", 16'h9F0F, 1'b0, 8'h03, 8'h00, 8'h00, SRC_FIX, 7'h7C, 7'h18);
        add_row("ora_rd2", 16'h9F01, 1'b1, 8'h00, 8'hFF, 8'hB3, SRC_FIX, 7'h7C, 7'h18);
        add_row("ddra_rd", 16'h9F03, 1'b1, 8'h00, 8'hFF, 8'h0F, SRC_FIX, 7'h00, 7'h00);
        add_row("orb_rd_in", 16'h9F00, 1'b1, 8'h00, 8'hFE, 8'hC2, SRC_FIX, 7'h02, 7'h02);
        add_row("ddrb_wr", 16'h9F02, 1'b0, 8'h03, 8'h00, 8'h00, SRC_FIX, 7'h03, 7'h00);
        add_row("orb_wr2", 16'h9F00, 1'b0, 8'h02, 8'h00, 8'h00, SRC_FIX, 7'h03, 7'h02);
        add_row("orb_wr1", 16'h9F00, 1'b0, 8'h01, 8'h00, 8'h00, SRC_FIX, 7'h03, 7'h01);
        add_row("orb_rd_out", 16'h9F00, 1'b1, 8'h00, 8'hFF, 8'hC1, SRC_FIX, 7'h03, 7'h01);
    endtask

    // Returns one tick after the edge where CPHI2 fell, i.e. 1 ns into PH0
    task automatic wait_cphi2_fall(output logic ok);
        logic prev;
        ok   = 1'b0;
        prev = cphi2_o;
        for (int n = 0; n < 12 && !ok; n++)
        begin
            @(posedge clk6x);
            #1;
            if (prev && !cphi2_o)
                ok = 1'b1;
            prev = cphi2_o;
        end
    endtask

    task automatic apply_row(input int i);
        logic [7:0] wd;
        logic [7:0] ex;
        wd = t_wdata[i];
        ex = t_exprd[i];
        if (t_src[i] == SRC_LFSR)
        begin
            next_byte(wd);
            sram_q.push_back(wd);
        end
        else if (t_src[i] == SRC_QUEUE && sram_q.size() > 0)
            ex = sram_q.pop_front();
        ca_i      = t_addr[i][15:12];
        mal_i     = t_addr[i][11:0];
        crwn_i    = t_rwn[i];
        cd_i      = wd;
        virq_n_i  = ~virq_n_i;      // IRQ level flips every row
        row_name  = t_name[i];
        row_via   = (t_addr[i][15:4] == 12'h9F0);
        exp_rd    = ex;
        rd_mask   = t_rdmask[i];
        pin_mask  = t_pmask[i];
        pin_exp   = t_pexp[i];
        row_valid = 1'b1;
    endtask

    initial
    begin
        logic ok;
        logic led_start;
        clk6x = 1'b0;
        arst_n_i = 1'b1;
        ca_i = 4'h0;
        mal_i = 12'h000;
        crwn_i = 1'b1;          // Idle cycles read address 0
        cd_i = 8'h00;
        virq_n_i = 1'b1;
        nes_data0_i = 1'b1;
        nes_data1_i = 1'b0;
        i2c_scl_i = 1'b1;
        i2c_sda_i = 1'b0;
        row_valid = 1'b0;
        row_name = '0;
        row_via = 1'b0;
        exp_rd = 8'h00;
        rd_mask = 8'h00;
        pin_mask = 7'h00;
        pin_exp = 7'h00;
        timeouts = 0;
        lfsr_r = 32'h3c293c20;
        for (int a = 0; a < 65536; a++)
            mem[a] = 8'hA5 ^ a[7:0] ^ a[15:8];
        load_table();
        #1 arst_n_i = 1'b0;
        repeat (3) @(posedge clk6x);
        #1 arst_n_i = 1'b1;
        ok = 1'b0;
        for (int n = 0; n < 100 && !ok; n++)
        begin
            @(posedge clk6x);
            #1;
            if (cresn_o)
                ok = 1'b1;
        end
        if (!ok)
            $display("Timeout: CPU reset never released");
        if (ok)
        begin
            led_start = cpu_led0_o;
            ok = 1'b0;
            for (int n = 0; n < 2 * int'(BLINK_DIV) && !ok; n++)
            begin
                @(posedge clk6x);
                #1;
                if (cpu_led0_o != led_start)
                    ok = 1'b1;
            end
            if (!ok)
                $display("Timeout: LED0 blinker did not toggle");
        end
        for (int i = 0; i < row_cnt && ok; i++)
        begin
            wait_cphi2_fall(ok);
            if (ok)
                apply_row(i);
            else
                $display("Timeout: CPU clock stopped before row %0d", i);
        end
        if (ok)
        begin
            wait_cphi2_fall(ok);    // Last row is checked before this fall
            row_valid = 1'b0;
            if (!ok)
                $display("Timeout: CPU clock stopped after the last row");
        end
        if (!ok)
            timeouts++;
        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timeouts);
        if (!ok || err_cnt != 0)
            $display("test failed");
        else
            $display("test passed");
        $finish;
    end

endmodule

//--- nora_core.f
source/nora_pkg.sv
source/nora_slv_if.sv
source/reset_gen.sv
source/cpu_phaser.sv
source/bus_controller.sv
source/via_regs.sv
source/gpio_port_map.sv
source/nora_core.sv
sim/nora_checker.sv
sim/tb_nora_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run with Verilator; a fail line in the log means failure
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log &&
verilator --binary --timing -f nora_core.f --top-module tb_nora_core -o vsim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/vsim > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && exit 1 || exit 0
